// File: common/line_xfer_pkg.sv
// Shared definitions for the cache line transfer design.
// Holds the fixed AXI4-Lite widths, the response code, the FSM state
// encodings and the packed channel structs between master and slave.
// Modules pull it in by a wildcard import in their header.

package line_xfer_pkg;

    localparam int AXI_ADDR_WIDTH = 32;
    localparam int AXI_DATA_WIDTH = 32;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    // ------------------------------------------------------------------
    // Channel payloads, master to slave and back.
    // ------------------------------------------------------------------
    typedef struct packed {
        logic                      valid;
        logic [AXI_ADDR_WIDTH-1:0] addr;
    } axi_addr_ch_t;

    typedef struct packed {
        logic                      valid;
        logic [AXI_DATA_WIDTH-1:0] data;
    } axi_wdata_ch_t;

    typedef struct packed {
        logic                      valid;
        logic [AXI_DATA_WIDTH-1:0] data;
        axi_resp_t                 resp;
    } axi_rdata_ch_t;

    typedef struct packed {
        logic      valid;
        axi_resp_t resp;
    } axi_bresp_ch_t;

    typedef struct packed {
        logic ar;
        logic r;
        logic aw;
        logic w;
        logic b;
    } axi_ready_t;

    // ------------------------------------------------------------------
    // FSM states.
    // ------------------------------------------------------------------
    typedef enum logic [2:0] {
        M_IDLE,
        M_READ_ADDR,
        M_READ_DATA,
        M_WRITE_ADDR_DATA,
        M_WRITE_RESP
    } master_state_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_MEM_ACCESS,
        S_READ_RESP,
        S_WRITE_RESP
    } slave_state_t;

    typedef enum logic [1:0] {
        X_IDLE,
        X_READ_WORD,
        X_WRITE_WORD
    } xfer_state_t;

endpackage

// File: axi4_lite/axi4_lite_master.sv
// AXI4-Lite master for single word accesses.
// A one-cycle start strobe launches one read or one write. The master
// drives the address channel (plus write data for writes), waits for
// the response and pulses o_done with the fault flag and read word.

module axi4_lite_master
    import line_xfer_pkg::*;
(
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_start_read,
    input  logic                      i_start_write,
    input  logic [AXI_ADDR_WIDTH-1:0] i_addr,
    input  logic [AXI_DATA_WIDTH-1:0] i_wdata,
    input  axi_ready_t                i_ready,
    input  axi_rdata_ch_t             i_rdata_ch,
    input  axi_bresp_ch_t             i_bresp_ch,
    output axi_addr_ch_t              o_ar_ch,
    output axi_addr_ch_t              o_aw_ch,
    output axi_wdata_ch_t             o_w_ch,
    output logic                      o_r_ready,
    output logic                      o_b_ready,
    output logic                      o_done,
    output logic                      o_read_fault,
    output logic                      o_write_fault,
    output logic [AXI_DATA_WIDTH-1:0] o_rdata
);

    master_state_t             state;
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic [AXI_DATA_WIDTH-1:0] wdata;
    logic                      ar_valid;
    logic                      aw_valid;
    logic                      w_valid;
    logic                      aw_left;
    logic                      w_left;

    assign o_ar_ch   = '{valid: ar_valid, addr: addr};
    assign o_aw_ch   = '{valid: aw_valid, addr: addr};
    assign o_w_ch    = '{valid: w_valid, data: wdata};
    assign o_r_ready = (state == M_READ_DATA);
    assign o_b_ready = (state == M_WRITE_RESP);

    // Write channels still unaccepted after this cycle.
    assign aw_left = aw_valid && !i_ready.aw;
    assign w_left  = w_valid && !i_ready.w;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state         <= M_IDLE;
            ar_valid      <= 1'b0;
            aw_valid      <= 1'b0;
            w_valid       <= 1'b0;
            o_done        <= 1'b0;
            o_read_fault  <= 1'b0;
            o_write_fault <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (i_start_read) begin
                        ar_valid <= 1'b1;
                        state    <= M_READ_ADDR;
                    end else if (i_start_write) begin
                        aw_valid <= 1'b1;
                        w_valid  <= 1'b1;
                        state    <= M_WRITE_ADDR_DATA;
                    end
                end
                M_READ_ADDR: begin
                    if (i_ready.ar) begin
                        ar_valid <= 1'b0;
                        state    <= M_READ_DATA;
                    end
                end
                M_READ_DATA: begin
                    if (i_rdata_ch.valid) begin
                        o_done        <= 1'b1;
                        o_read_fault  <= (i_rdata_ch.resp == SLVERR);
                        o_write_fault <= 1'b0;
                        state         <= M_IDLE;
                    end
                end
                M_WRITE_ADDR_DATA: begin
                    aw_valid <= aw_left;
                    w_valid  <= w_left;
                    if (!aw_left && !w_left) begin
                        state <= M_WRITE_RESP;
                    end
                end
                M_WRITE_RESP: begin
                    if (i_bresp_ch.valid) begin
                        o_done        <= 1'b1;
                        o_read_fault  <= 1'b0;
                        o_write_fault <= (i_bresp_ch.resp == SLVERR);
                        state         <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    // Request payload and returned word.
    always_ff @(posedge i_clk) begin
        if (state == M_IDLE && (i_start_read || i_start_write)) begin
            addr  <= i_addr;
            wdata <= i_wdata;
        end
        if (state == M_READ_DATA && i_rdata_ch.valid) begin
            o_rdata <= i_rdata_ch.data;
        end
    end

    // A raised valid holds with its payload until the slave takes it.
    a_ar_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        o_ar_ch.valid && !i_ready.ar |=> o_ar_ch.valid && $stable(o_ar_ch.addr));
    a_aw_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        o_aw_ch.valid && !i_ready.aw |=> o_aw_ch.valid && $stable(o_aw_ch.addr));
    a_w_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        o_w_ch.valid && !i_ready.w |=> o_w_ch.valid && $stable(o_w_ch.data));

endmodule

// File: axi4_lite/axi4_lite_slave.sv
// AXI4-Lite slave in front of the word memory.
// Takes one read or one write at a time, does a single memory access
// and holds the OKAY or SLVERR response until the master accepts it.
// Only the ar, aw and w bits of o_ready are driven here.

module axi4_lite_slave
    import line_xfer_pkg::*;
#(
    parameter int MEM_DEPTH = 256
) (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  axi_addr_ch_t              i_ar_ch,
    input  axi_addr_ch_t              i_aw_ch,
    input  axi_wdata_ch_t             i_w_ch,
    input  logic                      i_r_ready,
    input  logic                      i_b_ready,
    input  logic [AXI_DATA_WIDTH-1:0] i_mem_rdata,
    input  logic                      i_mem_fault,
    output axi_ready_t                o_ready,
    output axi_rdata_ch_t             o_rdata_ch,
    output axi_bresp_ch_t             o_bresp_ch,
    output logic                      o_mem_we,
    output logic [AXI_ADDR_WIDTH-1:0] o_mem_addr,
    output logic [AXI_DATA_WIDTH-1:0] o_mem_wdata
);

    slave_state_t              state;
    logic                      idle;
    logic                      rd_accept;
    logic                      wr_accept;
    logic                      is_write;
    logic                      r_valid;
    logic                      b_valid;
    logic [AXI_DATA_WIDTH-1:0] rdata;
    axi_resp_t                 resp;

    assign idle      = (state == S_IDLE);
    assign rd_accept = idle && i_ar_ch.valid;
    // Write address and data are taken together, reads first.
    assign wr_accept = idle && !i_ar_ch.valid && i_aw_ch.valid && i_w_ch.valid;

    assign o_ready = '{ar: idle, r: 1'b0, aw: wr_accept, w: wr_accept, b: 1'b0};

    // Memory sees the access in the handshake cycle.
    assign o_mem_we    = wr_accept;
    assign o_mem_addr  = (i_ar_ch.valid ? i_ar_ch.addr : i_aw_ch.addr) >> 2;
    assign o_mem_wdata = i_w_ch.data;

    assign o_rdata_ch = '{valid: r_valid, data: rdata, resp: resp};
    assign o_bresp_ch = '{valid: b_valid, resp: resp};

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state   <= S_IDLE;
            r_valid <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (rd_accept || wr_accept) begin
                        state <= S_MEM_ACCESS;
                    end
                end
                S_MEM_ACCESS: begin
                    r_valid <= !is_write;
                    b_valid <= is_write;
                    state   <= is_write ? S_WRITE_RESP : S_READ_RESP;
                end
                S_READ_RESP: begin
                    if (i_r_ready) begin
                        r_valid <= 1'b0;
                        state   <= S_IDLE;
                    end
                end
                S_WRITE_RESP: begin
                    if (i_b_ready) begin
                        b_valid <= 1'b0;
                        state   <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (idle) begin
            is_write <= wr_accept;
        end
        if (state == S_MEM_ACCESS) begin
            rdata <= i_mem_rdata;
            resp  <= i_mem_fault ? SLVERR : OKAY;
        end
    end

    // The memory flags exactly the word indices beyond its depth.
    a_fault_range: assert property (@(posedge i_clk) disable iff (i_reset)
        state == S_MEM_ACCESS |-> i_mem_fault == ($past(o_mem_addr) >= 32'(MEM_DEPTH)));

endmodule

// File: axi4_lite/axi4_lite_top.sv
// AXI4-Lite block with a master on the request side and a slave on
// the memory side. Word requests come in as start strobes and leave
// as single memory accesses; o_done closes each word.

module axi4_lite_top
    import line_xfer_pkg::*;
#(
    parameter int MEM_DEPTH = 256
) (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_start_read,
    input  logic                      i_start_write,
    input  logic [AXI_ADDR_WIDTH-1:0] i_addr,
    input  logic [AXI_DATA_WIDTH-1:0] i_wdata,
    input  logic [AXI_DATA_WIDTH-1:0] i_mem_rdata,
    input  logic                      i_mem_fault,
    output logic                      o_done,
    output logic                      o_read_fault,
    output logic                      o_write_fault,
    output logic [AXI_DATA_WIDTH-1:0] o_rdata,
    output logic                      o_mem_we,
    output logic [AXI_ADDR_WIDTH-1:0] o_mem_addr,
    output logic [AXI_DATA_WIDTH-1:0] o_mem_wdata
);

    axi_addr_ch_t  ar_ch;
    axi_addr_ch_t  aw_ch;
    axi_wdata_ch_t w_ch;
    axi_rdata_ch_t rdata_ch;
    axi_bresp_ch_t bresp_ch;
    axi_ready_t    slave_ready;
    axi_ready_t    ready;
    logic          r_ready;
    logic          b_ready;

    // Response readies come from the master, the rest from the slave.
    assign ready = '{ar: slave_ready.ar, r: r_ready, aw: slave_ready.aw,
                     w: slave_ready.w, b: b_ready};

    axi4_lite_master MASTER_M (
        .i_clk         ( i_clk         ),
        .i_reset       ( i_reset       ),
        .i_start_read  ( i_start_read  ),
        .i_start_write ( i_start_write ),
        .i_addr        ( i_addr        ),
        .i_wdata       ( i_wdata       ),
        .i_ready       ( ready         ),
        .i_rdata_ch    ( rdata_ch      ),
        .i_bresp_ch    ( bresp_ch      ),
        .o_ar_ch       ( ar_ch         ),
        .o_aw_ch       ( aw_ch         ),
        .o_w_ch        ( w_ch          ),
        .o_r_ready     ( r_ready       ),
        .o_b_ready     ( b_ready       ),
        .o_done        ( o_done        ),
        .o_read_fault  ( o_read_fault  ),
        .o_write_fault ( o_write_fault ),
        .o_rdata       ( o_rdata       )
    );

    axi4_lite_slave #(
        .MEM_DEPTH ( MEM_DEPTH )
    ) SLAVE_S (
        .i_clk       ( i_clk       ),
        .i_reset     ( i_reset     ),
        .i_ar_ch     ( ar_ch       ),
        .i_aw_ch     ( aw_ch       ),
        .i_w_ch      ( w_ch        ),
        .i_r_ready   ( r_ready     ),
        .i_b_ready   ( b_ready     ),
        .i_mem_rdata ( i_mem_rdata ),
        .i_mem_fault ( i_mem_fault ),
        .o_ready     ( slave_ready ),
        .o_rdata_ch  ( rdata_ch    ),
        .o_bresp_ch  ( bresp_ch    ),
        .o_mem_we    ( o_mem_we    ),
        .o_mem_addr  ( o_mem_addr  ),
        .o_mem_wdata ( o_mem_wdata )
    );

endmodule

// File: hdl/word_mem.sv
// Simulated word memory behind the AXI4-Lite slave.
// Read data and the out-of-range flag arrive one cycle after the
// address. Out-of-range writes are dropped and reads return zero.

module word_mem
    import line_xfer_pkg::*;
#(
    parameter int MEM_DEPTH = 256
) (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_write_en,
    input  logic [AXI_ADDR_WIDTH-1:0] i_addr,
    input  logic [AXI_DATA_WIDTH-1:0] i_wdata,
    output logic [AXI_DATA_WIDTH-1:0] o_rdata,
    output logic                      o_access_fault
);

    localparam int IDX_W = $clog2(MEM_DEPTH);

    logic [AXI_DATA_WIDTH-1:0] mem [MEM_DEPTH];
    logic                      in_range;
    logic [IDX_W-1:0]          idx;

    assign in_range = (i_addr < 32'(MEM_DEPTH));
    assign idx      = i_addr[IDX_W-1:0];

    always_ff @(posedge i_clk) begin
        if (i_write_en && in_range) begin
            mem[idx] <= i_wdata;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_rdata        <= '0;
            o_access_fault <= 1'b0;
        end else begin
            o_rdata        <= in_range ? mem[idx] : '0;
            o_access_fault <= !in_range;
        end
    end

endmodule

// File: hdl/cache_data_transfer.sv
// Cache line transfer unit.
// Walks a line word by word, one AXI request per word. Writes shift
// the line out from the low word up; reads shift returned words in
// from the top, so the line is in place after the last word.
// A fault ends the line early with o_fault set alongside o_done.

module cache_data_transfer
    import line_xfer_pkg::*;
#(
    parameter int LINE_WORDS = 16
) (
    input  logic                                 i_clk,
    input  logic                                 i_reset,
    input  logic                                 i_start_read,
    input  logic                                 i_start_write,
    input  logic [AXI_ADDR_WIDTH-1:0]            i_line_addr,
    input  logic [LINE_WORDS*AXI_DATA_WIDTH-1:0] i_line_wdata,
    input  logic                                 i_axi_done,
    input  logic                                 i_axi_fault,
    input  logic [AXI_DATA_WIDTH-1:0]            i_axi_rdata,
    output logic                                 o_busy,
    output logic                                 o_done,
    output logic                                 o_fault,
    output logic [LINE_WORDS*AXI_DATA_WIDTH-1:0] o_line_rdata,
    output logic                                 o_axi_start_read,
    output logic                                 o_axi_start_write,
    output logic [AXI_ADDR_WIDTH-1:0]            o_axi_addr,
    output logic [AXI_DATA_WIDTH-1:0]            o_axi_wdata
);

    localparam int LINE_W = LINE_WORDS * AXI_DATA_WIDTH;
    localparam int CNT_W  = $clog2(LINE_WORDS);

    xfer_state_t               state;
    logic [CNT_W-1:0]          count;
    logic [AXI_ADDR_WIDTH-1:0] line_addr;
    logic [LINE_W-1:0]         line;
    logic                      last_word;
    logic                      word_pending;

    assign o_busy       = (state != X_IDLE);
    assign o_axi_addr   = line_addr + (AXI_ADDR_WIDTH'(count) << 2);
    assign o_axi_wdata  = line[AXI_DATA_WIDTH-1:0];
    assign o_line_rdata = line;
    assign last_word    = (count == CNT_W'(LINE_WORDS - 1));

    // ------------------------------------------------------------------
    // Word sequencing.
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state             <= X_IDLE;
            count             <= '0;
            o_done            <= 1'b0;
            o_fault           <= 1'b0;
            o_axi_start_read  <= 1'b0;
            o_axi_start_write <= 1'b0;
        end else begin
            o_done            <= 1'b0;
            o_axi_start_read  <= 1'b0;
            o_axi_start_write <= 1'b0;
            case (state)
                X_IDLE: begin
                    count <= '0;
                    if (i_start_read) begin
                        o_axi_start_read <= 1'b1;
                        state            <= X_READ_WORD;
                    end else if (i_start_write) begin
                        o_axi_start_write <= 1'b1;
                        state             <= X_WRITE_WORD;
                    end
                end
                X_READ_WORD, X_WRITE_WORD: begin
                    if (i_axi_done) begin
                        if (i_axi_fault || last_word) begin
                            o_done  <= 1'b1;
                            o_fault <= i_axi_fault;
                            state   <= X_IDLE;
                        end else begin
                            count             <= count + CNT_W'(1);
                            o_axi_start_read  <= (state == X_READ_WORD);
                            o_axi_start_write <= (state == X_WRITE_WORD);
                        end
                    end
                end
                default: state <= X_IDLE;
            endcase
        end
    end

    // Line shift register, shared by reads and writes.
    always_ff @(posedge i_clk) begin
        if (state == X_IDLE && (i_start_read || i_start_write)) begin
            line_addr <= i_line_addr;
            line      <= i_line_wdata;
        end else if (state != X_IDLE && i_axi_done) begin
            line <= {i_axi_rdata, line[LINE_W-1:AXI_DATA_WIDTH]};
        end
    end

    // Word issued and not yet answered.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            word_pending <= 1'b0;
        end else if (o_axi_start_read || o_axi_start_write) begin
            word_pending <= 1'b1;
        end else if (i_axi_done) begin
            word_pending <= 1'b0;
        end
    end

    a_no_overlap: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_axi_start_read || o_axi_start_write) |-> !word_pending);
    a_done_answers: assert property (@(posedge i_clk) disable iff (i_reset)
        i_axi_done |-> word_pending);

endmodule

// File: hdl/line_xfer_top.sv
// Top level of the cache line transfer design.
// Connects the line transfer unit to the AXI4-Lite block and the word
// memory behind it. A start pulse moves one whole line.

module line_xfer_top
    import line_xfer_pkg::*;
#(
    parameter int LINE_WORDS = 16,
    parameter int MEM_DEPTH  = 256
) (
    input  logic                                 i_clk,
    input  logic                                 i_reset,
    input  logic                                 i_start_read,
    input  logic                                 i_start_write,
    input  logic [AXI_ADDR_WIDTH-1:0]            i_line_addr,
    input  logic [LINE_WORDS*AXI_DATA_WIDTH-1:0] i_line_wdata,
    output logic                                 o_busy,
    output logic                                 o_done,
    output logic                                 o_fault,
    output logic [LINE_WORDS*AXI_DATA_WIDTH-1:0] o_line_rdata
);

    logic                      axi_start_read;
    logic                      axi_start_write;
    logic                      axi_done;
    logic                      read_fault;
    logic                      write_fault;
    logic [AXI_ADDR_WIDTH-1:0] axi_addr;
    logic [AXI_DATA_WIDTH-1:0] axi_wdata;
    logic [AXI_DATA_WIDTH-1:0] axi_rdata;
    logic                      mem_we;
    logic                      mem_fault;
    logic [AXI_ADDR_WIDTH-1:0] mem_addr;
    logic [AXI_DATA_WIDTH-1:0] mem_wdata;
    logic [AXI_DATA_WIDTH-1:0] mem_rdata;

    cache_data_transfer #(
        .LINE_WORDS ( LINE_WORDS )
    ) DATA_T0 (
        .i_clk             ( i_clk                    ),
        .i_reset           ( i_reset                  ),
        .i_start_read      ( i_start_read             ),
        .i_start_write     ( i_start_write            ),
        .i_line_addr       ( i_line_addr              ),
        .i_line_wdata      ( i_line_wdata             ),
        .i_axi_done        ( axi_done                 ),
        .i_axi_fault       ( read_fault | write_fault ),
        .i_axi_rdata       ( axi_rdata                ),
        .o_busy            ( o_busy                   ),
        .o_done            ( o_done                   ),
        .o_fault           ( o_fault                  ),
        .o_line_rdata      ( o_line_rdata             ),
        .o_axi_start_read  ( axi_start_read           ),
        .o_axi_start_write ( axi_start_write          ),
        .o_axi_addr        ( axi_addr                 ),
        .o_axi_wdata       ( axi_wdata                )
    );

    axi4_lite_top #(
        .MEM_DEPTH ( MEM_DEPTH )
    ) AXI4_LITE_T (
        .i_clk         ( i_clk           ),
        .i_reset       ( i_reset         ),
        .i_start_read  ( axi_start_read  ),
        .i_start_write ( axi_start_write ),
        .i_addr        ( axi_addr        ),
        .i_wdata       ( axi_wdata       ),
        .i_mem_rdata   ( mem_rdata       ),
        .i_mem_fault   ( mem_fault       ),
        .o_done        ( axi_done        ),
        .o_read_fault  ( read_fault      ),
        .o_write_fault ( write_fault     ),
        .o_rdata       ( axi_rdata       ),
        .o_mem_we      ( mem_we          ),
        .o_mem_addr    ( mem_addr        ),
        .o_mem_wdata   ( mem_wdata       )
    );

    word_mem #(
        .MEM_DEPTH ( MEM_DEPTH )
    ) MEM_M (
        .i_clk          ( i_clk     ),
        .i_reset        ( i_reset   ),
        .i_write_en     ( mem_we    ),
        .i_addr         ( mem_addr  ),
        .i_wdata        ( mem_wdata ),
        .o_rdata        ( mem_rdata ),
        .o_access_fault ( mem_fault )
    );

endmodule

// File: bench/line_xfer_tb.sv
// Testbench for the cache line transfer design.
// Writes random lines through line_xfer_top, reads them back and
// compares each finished transfer with a line model kept here.
// Checks are concurrent assertions; any failure stops the run.

module line_xfer_tb
    import line_xfer_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LINE_WORDS = 16;
    localparam int MEM_DEPTH  = 256;
    localparam int LINE_W     = LINE_WORDS * AXI_DATA_WIDTH;
    localparam int LINE_BYTES = LINE_WORDS * 4;
    localparam int LINES      = MEM_DEPTH / LINE_WORDS;
    localparam int SEED       = 54582;
    localparam bit WR         = 1'b1;
    localparam bit RD         = 1'b0;
    // About 17 line transfers of 16 words at roughly 5 cycles a word,
    // plus idle gaps, with a wide margin.
    localparam int MAX_CYCLES = 3000;

    typedef logic [LINE_W-1:0] line_t;

    logic                      clk;
    logic                      reset;
    logic                      start_read;
    logic                      start_write;
    logic [AXI_ADDR_WIDTH-1:0] line_addr;
    line_t                     line_wdata;
    logic                      busy;
    logic                      done;
    logic                      fault;
    line_t                     line_rdata;

    // Expected outcome of the transfer in flight.
    line_t model [logic [AXI_ADDR_WIDTH-1:0]];
    line_t exp_line;
    bit    exp_read;
    bit    exp_fault;
    bit    xfer_open;
    int    cycle_count = 0;

    line_xfer_top #(
        .LINE_WORDS ( LINE_WORDS ),
        .MEM_DEPTH  ( MEM_DEPTH  )
    ) DUT (
        .i_clk         ( clk         ),
        .i_reset       ( reset       ),
        .i_start_read  ( start_read  ),
        .i_start_write ( start_write ),
        .i_line_addr   ( line_addr   ),
        .i_line_wdata  ( line_wdata  ),
        .o_busy        ( busy        ),
        .o_done        ( done        ),
        .o_fault       ( fault       ),
        .o_line_rdata  ( line_rdata  )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    function automatic line_t rand_line();
        line_t l;
        for (int w = 0; w < LINE_WORDS; w++) begin
            l[w*AXI_DATA_WIDTH +: AXI_DATA_WIDTH] = $urandom();
        end
        return l;
    endfunction

    function automatic logic [AXI_ADDR_WIDTH-1:0] addr_of_line(input int index);
        return 32'(index * LINE_BYTES);
    endfunction

    // Faults when the last word of the line lies past the memory.
    function automatic bit line_beyond(input logic [AXI_ADDR_WIDTH-1:0] addr);
        return ((addr >> 2) + 32'(LINE_WORDS - 1)) >= 32'(MEM_DEPTH);
    endfunction

    // ------------------------------------------------------------------
    // One line transfer, with an optional ignored start mid-line.
    // ------------------------------------------------------------------
    task automatic run_xfer(input bit is_write, input logic [AXI_ADDR_WIDTH-1:0] addr,
                            input line_t data, input bit extra_start);
        int waited;
        @(negedge clk);
        exp_read    = !is_write;
        exp_fault   = line_beyond(addr);
        exp_line    = (!is_write && model.exists(addr)) ? model[addr] : '0;
        line_addr   = addr;
        line_wdata  = data;
        start_write = is_write;
        start_read  = !is_write;
        @(negedge clk);
        start_write = 1'b0;
        start_read  = 1'b0;
        waited = 0;
        while (!done) begin
            @(negedge clk);
            waited++;
            // Opposite kind of start while busy.
            if (extra_start && waited == 8) begin
                start_read  = is_write;
                start_write = !is_write;
            end else begin
                start_read  = 1'b0;
                start_write = 1'b0;
            end
        end
        if (is_write && !exp_fault) begin
            model[addr] = data;
        end
    endtask

    // Accepted starts open a transfer, o_done closes it.
    always @(posedge clk) begin
        if (reset) begin
            xfer_open <= 1'b0;
        end else if (done) begin
            xfer_open <= 1'b0;
        end else if ((start_read || start_write) && !busy) begin
            xfer_open <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout: tests not finished after %0d cycles", MAX_CYCLES));
        end
    end

    // ------------------------------------------------------------------
    // Checks.
    // ------------------------------------------------------------------
    a_reset_quiet: assert property (@(posedge clk) reset |=> !busy && !done && !fault)
        else abort_run($sformatf("Mismatch at %0t: busy, done or fault high after reset",
                                 $time));
    a_busy: assert property (@(posedge clk) disable iff (reset)
        xfer_open && !done |-> busy)
        else abort_run($sformatf("Mismatch at %0t: o_busy low during a transfer", $time));
    a_fault: assert property (@(posedge clk) disable iff (reset)
        done |-> fault == exp_fault)
        else abort_run($sformatf("Mismatch at %0t: o_fault is %0b, expected %0b",
                                 $time, fault, exp_fault));
    a_rdata: assert property (@(posedge clk) disable iff (reset)
        done && exp_read && !exp_fault |-> line_rdata == exp_line)
        else abort_run($sformatf("Mismatch at %0t: read line %h, expected %h",
                                 $time, line_rdata, exp_line));
    a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else abort_run("o_done stayed high for more than one cycle");
    a_done_once: assert property (@(posedge clk) disable iff (reset) done |-> xfer_open)
        else abort_run("o_done came without an accepted start");

    // ------------------------------------------------------------------
    // Stimulus.
    // ------------------------------------------------------------------
    initial begin
        int idx [4];
        int order [4];
        bit taken [LINES];
        int buddy;
        reset       = 1'b1;
        start_read  = 1'b0;
        start_write = 1'b0;
        line_addr   = '0;
        line_wdata  = '0;
        exp_line    = '0;
        exp_read    = 1'b0;
        exp_fault   = 1'b0;
        void'($urandom(SEED));
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // Four distinct lines written, then read back shuffled.
        for (int i = 0; i < 4; i++) begin
            do begin
                idx[i] = int'($urandom_range(LINES - 1));
            end while (taken[idx[i]]);
            taken[idx[i]] = 1'b1;
        end
        for (int i = 0; i < 4; i++) begin
            run_xfer(WR, addr_of_line(idx[i]), rand_line(), 1'b0);
        end
        order = '{2, 0, 3, 1};
        for (int i = 0; i < 4; i++) begin
            run_xfer(RD, addr_of_line(idx[order[i]]), '0, 1'b0);
        end

        // Overwrite one line; its neighbor keeps the old data.
        buddy = idx[0] ^ 1;
        if (!model.exists(addr_of_line(buddy))) begin
            run_xfer(WR, addr_of_line(buddy), rand_line(), 1'b0);
        end
        run_xfer(WR, addr_of_line(idx[0]), rand_line(), 1'b0);
        run_xfer(RD, addr_of_line(idx[0]), '0, 1'b0);
        run_xfer(RD, addr_of_line(buddy), '0, 1'b0);

        // Lines past the memory fault, and leave memory intact.
        run_xfer(RD, addr_of_line(LINES + idx[1]), '0, 1'b0);
        run_xfer(WR, addr_of_line(LINES + idx[1]), rand_line(), 1'b0);
        run_xfer(RD, addr_of_line(idx[1]), '0, 1'b0);

        // Starts while busy are dropped.
        run_xfer(WR, addr_of_line(idx[2]), rand_line(), 1'b1);
        run_xfer(RD, addr_of_line(idx[2]), '0, 1'b1);
        repeat (100) @(negedge clk);

        $display("TEST OK");
        $finish;
    end

endmodule

// File: compile.f
common/line_xfer_pkg.sv
axi4_lite/axi4_lite_master.sv
axi4_lite/axi4_lite_slave.sv
axi4_lite/axi4_lite_top.sv
hdl/word_mem.sv
hdl/cache_data_transfer.sv
hdl/line_xfer_top.sv
bench/line_xfer_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the line transfer simulation with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module line_xfer_tb \
    -f compile.f \
    -o line_xfer_sim

./obj_dir/line_xfer_sim
